// File: sources.f
hdl/rv_isa_pkg.sv
hdl/rv_exec_pkg.sv
hdl/rv_decode.sv
hdl/rv_alu.sv
hdl/rv_result.sv
hdl/rv_exec_unit.sv
dv/rv_exec_unit_tb.sv

// File: Bender.yml
package:
  name: rv_exec_unit

sources:
  # packages first
  - hdl/rv_isa_pkg.sv
  - hdl/rv_exec_pkg.sv
  # rtl
  - hdl/rv_decode.sv
  - hdl/rv_alu.sv
  - hdl/rv_result.sv
  - hdl/rv_exec_unit.sv
  # testbench
  - target: test
    files:
      - dv/rv_exec_unit_tb.sv

// File: dv/rv_exec_unit_tb.sv
`default_nettype none

module rv_exec_unit_tb;

  import rv_isa_pkg::*;
  import rv_exec_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          SEED       = 86106;
  localparam int          N_RAND     = 400;
  localparam int          STALL_AT   = 8;   // table row that follows the long stall
  localparam int          STALL_LEN  = 4;
  localparam logic [31:0] PC0        = 32'h0000_0100;
  localparam logic [31:0] PCB        = 32'h0000_1000;

  typedef enum logic [2:0] {K_WRITE, K_TAKEN, K_FALL, K_ILLEGAL, K_NONE} kind_e;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] rs1;
    logic [31:0] rs2;
    kind_e       kind;
    logic [31:0] value;  // result or branch target
  } tab_entry_t;

  typedef struct packed {
    wb_t       wb;
    redirect_t redir;
  } exp_t;

  logic       clk_in;
  logic       rst;
  logic       rdy_in;
  issue_t     issue;
  wb_t        wb;
  redirect_t  redir;

  tab_entry_t table_q[$];
  exp_t       exp_q[$];
  int         pending = 0;
  logic       loaded = 1'b0;

  rv_exec_unit dut0 (
    .clk_in (clk_in),
    .rst    (rst),
    .rdy_in (rdy_in),
    .issue  (issue),
    .wb     (wb),
    .redir  (redir)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  task automatic end_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic check_wb(input string name, input wb_t got, input wb_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got valid=%b rd=%0d value=%h illegal=%b", $time, name,
               got.valid, got.rd, got.value, got.illegal,
               " expected valid=%b rd=%0d value=%h illegal=%b",
               exp.valid, exp.rd, exp.value, exp.illegal);
      end_with_failure();
    end
  endtask

  task automatic check_redirect(input string name, input redirect_t got, input redirect_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got valid=%b taken=%b target=%h", $time, name,
               got.valid, got.taken, got.target,
               " expected valid=%b taken=%b target=%h", exp.valid, exp.taken, exp.target);
      end_with_failure();
    end
  endtask

  // always rd x5 with rs1 x1 and rs2 x2
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
    enc_r = {f7, 5'd2, 5'd1, f3, 5'd5, OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3);
    enc_i = {imm, 5'd1, f3, 5'd5, OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] opc);
    enc_u = {imm, 5'd5, opc};
  endfunction

  task automatic add_row(input logic [31:0] w, input logic [31:0] pc, input logic [31:0] a,
                         input logic [31:0] b, input kind_e k, input logic [31:0] v);
    tab_entry_t t;
    t.instr = w;
    t.pc    = pc;
    t.rs1   = a;
    t.rs2   = b;
    t.kind  = k;
    t.value = v;
    table_q.push_back(t);
  endtask

  task automatic load_table();
    add_row(enc_r(7'h00, F3_ADD_SUB), PC0, 32'h7fff_ffff, 32'h1, K_WRITE, 32'h8000_0000);
    add_row(enc_r(F7_ALT, F3_ADD_SUB), PC0, 32'h0, 32'h1, K_WRITE, 32'hffff_ffff);
    add_row(enc_r(7'h00, F3_AND), PC0, 32'hf0f0_f0f0, 32'hff00_ff00, K_WRITE, 32'hf000_f000);
    add_row(enc_r(7'h00, F3_OR), PC0, 32'hf0f0_f0f0, 32'h0f0f_0000, K_WRITE, 32'hffff_f0f0);
    add_row(enc_r(7'h00, F3_XOR), PC0, 32'haaaa_aaaa, 32'hffff_ffff, K_WRITE, 32'h5555_5555);
    add_row(enc_r(7'h00, F3_SLL), PC0, 32'h1, 32'h23, K_WRITE, 32'h8);
    add_row(enc_r(7'h00, F3_SR), PC0, 32'h8000_0000, 32'h1f, K_WRITE, 32'h1);
    add_row(enc_r(F7_ALT, F3_SR), PC0, 32'h8000_0000, 32'h4, K_WRITE, 32'hf800_0000);
    add_row(enc_r(7'h00, F3_SLT), PC0, 32'hffff_ffff, 32'h1, K_WRITE, 32'h1);
    add_row(enc_r(7'h00, F3_SLTU), PC0, 32'hffff_ffff, 32'h1, K_WRITE, 32'h0);
    add_row(enc_r(7'h00, F3_SLTU), PC0, 32'h1, 32'hffff_ffff, K_WRITE, 32'h1);
    add_row(enc_i(12'hfff, F3_ADD_SUB), PC0, 32'h5, 32'h0, K_WRITE, 32'h4);
    add_row(enc_i(12'hfff, F3_SLTU), PC0, 32'h1234_5678, 32'h0, K_WRITE, 32'h1);
    add_row(enc_i(12'h408, F3_SR), PC0, 32'h8000_0000, 32'h0, K_WRITE, 32'hff80_0000);
    add_row(enc_i(12'h004, F3_SLL), PC0, 32'hf, 32'h0, K_WRITE, 32'hf0);
    add_row(enc_i(12'h800, F3_XOR), PC0, 32'h0, 32'h0, K_WRITE, 32'hffff_f800);
    add_row(enc_u(20'hdeadb, OPC_LUI), PC0, 32'h0, 32'h0, K_WRITE, 32'hdead_b000);
    add_row(enc_u(20'hfffff, OPC_AUIPC), 32'h2000, 32'h0, 32'h0, K_WRITE, 32'h1000);
    add_row(enc_b(13'h0010, F3_BEQ), PCB, 32'h7, 32'h7, K_TAKEN, 32'h1010);
    add_row(enc_b(13'h0010, F3_BEQ), PCB, 32'h7, 32'h8, K_FALL, 32'h1004);
    add_row(enc_b(13'h1ff8, F3_BNE), PCB, 32'h7, 32'h8, K_TAKEN, 32'h0ff8);
    add_row(enc_b(13'h1ff8, F3_BNE), PCB, 32'h3, 32'h3, K_FALL, 32'h1004);
    add_row(enc_b(13'h0100, F3_BLT), PCB, 32'hffff_ffff, 32'h1, K_TAKEN, 32'h1100);
    add_row(enc_b(13'h0100, F3_BLT), PCB, 32'h1, 32'hffff_ffff, K_FALL, 32'h1004);
    add_row(enc_b(13'h1000, F3_BGE), PCB, 32'h5, 32'h5, K_TAKEN, 32'h0);
    add_row(enc_b(13'h1000, F3_BGE), PCB, 32'hffff_fffe, 32'h1, K_FALL, 32'h1004);
    add_row(enc_b(13'h0020, F3_BLTU), PCB, 32'h1, 32'hffff_ffff, K_TAKEN, 32'h1020);
    add_row(enc_b(13'h0020, F3_BLTU), PCB, 32'hffff_ffff, 32'h1, K_FALL, 32'h1004);
    add_row(enc_b(13'h0ffe, F3_BGEU), PCB, 32'hffff_ffff, 32'h1, K_TAKEN, 32'h1ffe);
    add_row(enc_b(13'h0ffe, F3_BGEU), PCB, 32'h0, 32'h1, K_FALL, 32'h1004);
    add_row(32'h0020_8033, PC0, 32'h1, 32'h2, K_NONE, 32'h0);     // add x0
    add_row(32'h0000_2283, PC0, 32'h1, 32'h2, K_ILLEGAL, 32'h0);  // lw
    add_row(enc_r(7'h01, F3_ADD_SUB), PC0, 32'h3, 32'h4, K_ILLEGAL, 32'h0);
    add_row(enc_i(12'h405, F3_SLL), PC0, 32'h3, 32'h0, K_ILLEGAL, 32'h0);
    add_row(enc_r(F7_ALT, F3_XOR), PC0, 32'h3, 32'h4, K_ILLEGAL, 32'h0);
  endtask

  function automatic exp_t table_expect(input tab_entry_t t);
    exp_t e;
    e = '0;
    case (t.kind)
      K_WRITE: begin
        e.wb.valid = 1'b1;
        e.wb.rd    = t.instr[11:7];
        e.wb.value = t.value;
      end
      K_ILLEGAL: begin
        e.wb.valid   = 1'b1;
        e.wb.illegal = 1'b1;
      end
      K_TAKEN, K_FALL: begin
        e.redir.valid  = 1'b1;
        e.redir.taken  = (t.kind == K_TAKEN);
        e.redir.target = t.value;
      end
      default: e = '0;
    endcase
    return e;
  endfunction

  // independent model for legal encodings
  function automatic exp_t ref_model(input logic [31:0] w, input logic [31:0] pc,
                                     input logic [31:0] a, input logic [31:0] b);
    exp_t        e;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] opb;
    logic [31:0] val;
    logic        cond;
    logic        alt;
    e     = '0;
    val   = '0;
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    alt   = (w[31:25] == F7_ALT);
    opb   = (w[6:0] == OPC_OP) ? b : imm_i;
    case (w[14:12])
      3'b000: val = (alt && w[6:0] == OPC_OP) ? a - opb : a + opb;
      3'b001: val = a << opb[4:0];
      3'b010: val = {31'b0, $signed(a) < $signed(opb)};
      3'b011: val = {31'b0, a < opb};
      3'b100: val = a ^ opb;
      3'b101: begin
        if (alt) val = $signed(a) >>> opb[4:0];
        else     val = a >> opb[4:0];
      end
      3'b110: val = a | opb;
      default: val = a & opb;
    endcase
    case (w[14:12])
      3'b000: cond = (a == b);
      3'b001: cond = (a != b);
      3'b100: cond = ($signed(a) < $signed(b));
      3'b101: cond = ($signed(a) >= $signed(b));
      3'b110: cond = (a < b);
      default: cond = (a >= b);
    endcase
    if (w[6:0] == OPC_LUI) val = {w[31:12], 12'b0};
    if (w[6:0] == OPC_AUIPC) val = pc + {w[31:12], 12'b0};
    if (w[6:0] == OPC_BRANCH) begin
      e.redir.valid  = 1'b1;
      e.redir.taken  = cond;
      e.redir.target = cond ? pc + imm_b : pc + 32'd4;
    end else if (w[11:7] != 5'd0) begin
      e.wb.valid = 1'b1;
      e.wb.rd    = w[11:7];
      e.wb.value = val;
    end
    return e;
  endfunction

  function automatic logic [31:0] random_legal();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = $urandom;
    s  = $urandom;
    f3 = r[14:12];
    f7 = (r[0] && (f3 == F3_ADD_SUB || f3 == F3_SR)) ? F7_ALT : 7'h00;
    case (s % 5)
      0: random_legal = {f7, r[24:7], OPC_OP};
      1: random_legal = {(f3 == F3_SLL || f3 == F3_SR) ? f7 : r[31:25], r[24:7], OPC_OP_IMM};
      2: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // no branch with funct3 010/011
        random_legal = {r[31:15], f3, r[11:7], OPC_BRANCH};
      end
      3: random_legal = {r[31:7], OPC_LUI};
      default: random_legal = {r[31:7], OPC_AUIPC};
    endcase
  endfunction

  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    r = $urandom;
    case (r[1:0])
      2'd0: pick_operand = 32'h8000_0000;
      2'd1: pick_operand = 32'hffff_ffff;
      2'd2: pick_operand = {29'b0, r[4:2]};
      default: pick_operand = $urandom;
    endcase
  endfunction

  task automatic send(input logic [31:0] w, input logic [31:0] pc, input logic [31:0] a,
                      input logic [31:0] b, input exp_t e);
    issue.valid   = 1'b1;
    issue.instr   = w;
    issue.pc      = pc;
    issue.rs1_val = a;
    issue.rs2_val = b;
    rdy_in        = 1'b1;
    exp_q.push_back(e);
    pending++;
    @(negedge clk_in);
  endtask

  // the stalled slice must drop this valid junk issue
  task automatic hold_ready_low(input int n);
    rdy_in      = 1'b0;
    issue.valid = 1'b1;
    issue.instr = enc_r(7'h00, F3_ADD_SUB);
    repeat (n) @(negedge clk_in);
    rdy_in      = 1'b1;
    issue.valid = 1'b0;
  endtask

  task automatic check_result(input exp_t e);
    if (wb.valid !== e.wb.valid)
      report_error(e.wb.valid ? "write-back strobe missing" : "unexpected write-back strobe");
    if (redir.valid !== e.redir.valid)
      report_error(e.redir.valid ? "redirect strobe missing" : "unexpected redirect strobe");
    if (e.wb.valid) check_wb("wb", wb, e.wb);
    if (e.redir.valid) check_redirect("redir", redir, e.redir);
  endtask

  initial begin : monitor
    exp_t       s1;
    exp_t       s2;
    logic       h1;
    logic       h2;
    logic [1:0] mode;  // 0 reset, 1 advance, 2 stall
    wb_t        last_wb;
    redirect_t  last_redir;
    h1 = 1'b0;
    h2 = 1'b0;
    s1 = '0;
    forever begin
      @(posedge clk_in);
      if (rst) begin
        mode = 2'd0;
        h1   = 1'b0;
      end else if (rdy_in) begin
        mode = 2'd1;
        s2   = s1;
        h2   = h1;
        h1   = issue.valid;
        if (issue.valid) begin
          if (exp_q.size() == 0) report_error("issue accepted with nothing queued");
          s1 = exp_q.pop_front();
        end
      end else begin
        mode = 2'd2;
      end
      @(negedge clk_in);
      if (mode == 2'd1) begin
        if (!h2) s2 = '0;
        check_result(s2);
        if (h2) pending--;
      end else if (mode == 2'd2) begin
        check_wb("wb during stall", wb, last_wb);
        check_redirect("redir during stall", redir, last_redir);
      end
      last_wb    = wb;
      last_redir = redir;
    end
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = table_q.size() + STALL_LEN + N_RAND + N_RAND / 16 + 32;
    #(limit * CLK_PERIOD);
    report_error("watchdog timeout, results did not drain in time");
  end

  initial begin : stimulus
    logic [31:0] pc;
    void'($urandom(SEED));
    rst     = 1'b1;
    rdy_in  = 1'b1;
    issue   = '0;
    load_table();
    loaded = 1'b1;
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst = 1'b0;
    foreach (table_q[i]) begin
      if (i == STALL_AT) hold_ready_low(STALL_LEN);
      send(table_q[i].instr, table_q[i].pc, table_q[i].rs1, table_q[i].rs2,
           table_expect(table_q[i]));
    end
    for (int n = 0; n < N_RAND; n++) begin
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      if (n % 16 == 15) hold_ready_low(1);
      w  = random_legal();
      a  = pick_operand();
      b  = pick_operand();
      pc = $urandom;
      pc[1:0] = 2'b00;
      send(w, pc, a, b, ref_model(w, pc, a, b));
    end
    issue.valid = 1'b0;
    while (pending != 0) @(posedge clk_in);
    repeat (2) @(posedge clk_in);  // idle edges must show no strobes
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/rv_exec_unit.sv
`default_nettype none

module rv_exec_unit (
  input  logic                   clk_in,
  input  logic                   rst,
  input  logic                   rdy_in,   // pauses both stages when low
  input  rv_exec_pkg::issue_t    issue,
  output rv_exec_pkg::wb_t       wb,
  output rv_exec_pkg::redirect_t redir
);

  import rv_exec_pkg::*;

  dec_t        dec;
  logic [31:0] alu_value;
  logic        br_taken;
  logic [31:0] br_target;

  rv_decode decode0 (
    .clk_in (clk_in),
    .rst    (rst),
    .rdy_in (rdy_in),
    .issue  (issue),
    .dec    (dec)
  );

  rv_alu alu0 (
    .dec       (dec),
    .alu_value (alu_value),
    .br_taken  (br_taken),
    .br_target (br_target)
  );

  rv_result result0 (
    .clk_in    (clk_in),
    .rst       (rst),
    .rdy_in    (rdy_in),
    .dec       (dec),
    .alu_value (alu_value),
    .br_taken  (br_taken),
    .br_target (br_target),
    .wb        (wb),
    .redir     (redir)
  );

endmodule

`default_nettype wire

// File: hdl/rv_result.sv
`default_nettype none

module rv_result (
  input  logic                   clk_in,
  input  logic                   rst,
  input  logic                   rdy_in,
  input  rv_exec_pkg::dec_t      dec,
  input  logic [31:0]            alu_value,
  input  logic                   br_taken,
  input  logic [31:0]            br_target,
  output rv_exec_pkg::wb_t       wb,
  output rv_exec_pkg::redirect_t redir
);

  import rv_exec_pkg::*;

  wb_t       wb_nxt;
  redirect_t redir_nxt;
  logic      is_branch;

  assign is_branch = dec.uop inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

  always_comb begin
    wb_nxt    = '0;
    redir_nxt = '0;
    if (dec.valid) begin
      if (dec.illegal) begin
        wb_nxt.valid   = 1'b1;   // rd and value stay zero
        wb_nxt.illegal = 1'b1;
      end else if (is_branch) begin
        redir_nxt.valid  = 1'b1;
        redir_nxt.taken  = br_taken;
        redir_nxt.target = br_target;
      end else if (dec.rd != 5'd0) begin
        wb_nxt.valid = 1'b1;
        wb_nxt.rd    = dec.rd;
        wb_nxt.value = alu_value;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      wb.valid    <= 1'b0;
      redir.valid <= 1'b0;
    end else if (rdy_in) begin
      wb    <= wb_nxt;
      redir <= redir_nxt;
    end
  end

  wb_redir_exclusive: assert property (@(posedge clk_in) disable iff (rst)
    !(wb.valid && redir.valid));

endmodule

`default_nettype wire

// File: hdl/rv_alu.sv
`default_nettype none

module rv_alu (
  input  rv_exec_pkg::dec_t dec,
  output logic [31:0]       alu_value,
  output logic              br_taken,
  output logic [31:0]       br_target
);

  import rv_exec_pkg::*;

  logic [4:0]      shamt;
  logic            eq;
  logic            lt_s;
  logic            lt_u;
  logic            is_branch;
  logic            br_cond;
  logic [XLEN-1:0] offset;

  assign shamt = dec.op_b[4:0];
  assign eq    = (dec.op_a == dec.op_b);
  assign lt_s  = ($signed(dec.op_a) < $signed(dec.op_b));
  assign lt_u  = (dec.op_a < dec.op_b);

  assign is_branch = dec.uop inside {BEQ, BNE, BLT, BGE, BLTU, BGEU};

  always_comb begin
    case (dec.uop)
      ADD:     alu_value = dec.op_a + dec.op_b;
      SUB:     alu_value = dec.op_a - dec.op_b;
      AND:     alu_value = dec.op_a & dec.op_b;
      OR:      alu_value = dec.op_a | dec.op_b;
      XOR:     alu_value = dec.op_a ^ dec.op_b;
      SLL:     alu_value = dec.op_a << shamt;
      SRL:     alu_value = dec.op_a >> shamt;
      SRA:     alu_value = $unsigned($signed(dec.op_a) >>> shamt);
      SLT:     alu_value = {31'b0, lt_s};
      SLTU:    alu_value = {31'b0, lt_u};
      LUI:     alu_value = dec.imm;
      AUIPC:   alu_value = dec.pc + dec.imm;
      default: alu_value = '0;     // branches and nop
    endcase
  end

  always_comb begin
    case (dec.uop)
      BEQ:     br_cond = eq;
      BNE:     br_cond = !eq;
      BLT:     br_cond = lt_s;
      BGE:     br_cond = !lt_s;
      BLTU:    br_cond = lt_u;
      BGEU:    br_cond = !lt_u;
      default: br_cond = 1'b0;
    endcase
  end

  assign br_taken  = br_cond;
  assign offset    = br_taken ? dec.imm : 32'd4;
  assign br_target = dec.pc + offset; // fall-through when not taken

  // compare flags must not leak into alu ops
  br_taken_only_on_branch: assert final (!br_taken || is_branch);

endmodule

`default_nettype wire

// File: hdl/rv_decode.sv
`default_nettype none

module rv_decode (
  input  logic                clk_in,
  input  logic                rst,
  input  logic                rdy_in,
  input  rv_exec_pkg::issue_t issue,
  output rv_exec_pkg::dec_t   dec
);

  import rv_isa_pkg::*;
  import rv_exec_pkg::*;

  instr_t          ins;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [2:0]      f3;
  logic [6:0]      f7_r;
  logic [6:0]      f7_i;
  dec_t            dec_nxt;

  function automatic uop_e alu_uop(input logic [2:0] funct3, input logic alt);
    case (funct3)
      F3_ADD_SUB: alu_uop = alt ? SUB : ADD;
      F3_SLL:     alu_uop = SLL;
      F3_SLT:     alu_uop = SLT;
      F3_SLTU:    alu_uop = SLTU;
      F3_XOR:     alu_uop = XOR;
      F3_SR:      alu_uop = alt ? SRA : SRL;
      F3_OR:      alu_uop = OR;
      F3_AND:     alu_uop = AND;
      default:    alu_uop = NOP;
    endcase
  endfunction

  assign ins   = issue.instr;
  assign f3    = ins.r.funct3;   // same bits in every view with a funct3
  assign f7_r  = ins.r.funct7;
  assign f7_i  = ins.i.imm[11:5];

  assign imm_i = {{20{ins.i.imm[11]}}, ins.i.imm};
  assign imm_b = {{19{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11,
                  ins.b.imm_10_5, ins.b.imm_4_1, 1'b0};
  assign imm_u = {ins.u.imm_31_12, 12'b0};

  always_comb begin
    dec_nxt         = '0;
    dec_nxt.valid   = issue.valid;
    dec_nxt.pc      = issue.pc;
    dec_nxt.op_a    = issue.rs1_val;
    dec_nxt.op_b    = issue.rs2_val;
    dec_nxt.rd      = ins.r.rd;
    dec_nxt.uop     = NOP;
    dec_nxt.illegal = 1'b0;

    case (ins.r.opcode)
      OPC_OP: begin
        if (f7_r == 7'b0 || (f7_r == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SR))) begin
          dec_nxt.uop = alu_uop(f3, f7_r == F7_ALT);
        end else begin
          dec_nxt.illegal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        dec_nxt.imm  = imm_i;
        dec_nxt.op_b = imm_i; // sltiu compares against the sign-extended value
        if (f3 == F3_SLL || f3 == F3_SR) begin
          dec_nxt.op_b = {27'b0, ins.i.imm[4:0]};
          if (f7_i == 7'b0 || (f3 == F3_SR && f7_i == F7_ALT)) begin
            dec_nxt.uop = alu_uop(f3, f7_i == F7_ALT);
          end else begin
            dec_nxt.illegal = 1'b1;
          end
        end else begin
          dec_nxt.uop = alu_uop(f3, 1'b0); // no subi
        end
      end
      OPC_BRANCH: begin
        dec_nxt.imm = imm_b;
        dec_nxt.rd  = 5'd0;
        case (f3)
          F3_BEQ:  dec_nxt.uop = BEQ;
          F3_BNE:  dec_nxt.uop = BNE;
          F3_BLT:  dec_nxt.uop = BLT;
          F3_BGE:  dec_nxt.uop = BGE;
          F3_BLTU: dec_nxt.uop = BLTU;
          F3_BGEU: dec_nxt.uop = BGEU;
          default: dec_nxt.illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        dec_nxt.imm = imm_u;
        dec_nxt.uop = LUI;
      end
      OPC_AUIPC: begin
        dec_nxt.imm = imm_u;
        dec_nxt.uop = AUIPC;
      end
      default: dec_nxt.illegal = 1'b1;
    endcase

    if (dec_nxt.illegal) begin
      dec_nxt.uop = NOP;
      dec_nxt.rd  = 5'd0;
    end
  end

  // payload fields carry no reset
  always_ff @(posedge clk_in) begin
    if (rst) begin
      dec.valid <= 1'b0;
    end else if (rdy_in) begin
      dec <= dec_nxt;
    end
  end

  nop_only_when_illegal: assert property (@(posedge clk_in) disable iff (rst)
    dec.valid && (dec.uop == NOP) |-> dec.illegal);

endmodule

`default_nettype wire

// File: hdl/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

  localparam int XLEN = 32;

  typedef enum logic [4:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    LUI,
    AUIPC,
    NOP    // illegal encodings only
  } uop_e;

  // from the reservation station
  typedef struct packed {
    logic                valid;
    rv_isa_pkg::instr_t  instr;
    logic [XLEN-1:0]     pc;
    logic [XLEN-1:0]     rs1_val;
    logic [XLEN-1:0]     rs2_val;
  } issue_t;

  // decode to alu
  typedef struct packed {
    logic            valid;
    uop_e            uop;
    logic [4:0]      rd;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;    // rs2_val, imm or shamt
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            illegal;
  } dec_t;

  typedef struct packed {
    logic            valid;
    logic [4:0]      rd;
    logic [XLEN-1:0] value;
    logic            illegal;
  } wb_t;

  typedef struct packed {
    logic            valid;
    logic            taken;
    logic [XLEN-1:0] target; // pc+4 when not taken
  } redirect_t;

endpackage

`default_nettype wire

// File: hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101; // srl / sra by funct7
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch conditions
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_ALT = 7'b0100000; // sub, sra

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;     // funct7 of shift-imm sits in imm[11:5]
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch offset is scattered, bit 0 implied zero
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    b_fmt_t b;
    u_fmt_t u;
  } instr_t;

endpackage

`default_nettype wire
